/* Makefile */
# Verilator build and run for the scalarCpu testbench

TOOL      = verilator
FLAGS     = --binary --timing -j 0
TOP       = processorTb
FILELIST  = scalarCpu.f
BUILD     = obj_dir
SIM       = $(BUILD)/V$(TOP)
LOG       = run.log
PASS_TEXT = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the simulator exit code is ignored so the log search alone decides the result
run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* design/controlUnit.sv */
// controlUnit
// instruction decoder and NZCV flag register for the single-cycle datapath
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import cpuPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  opcode_e               opcode,
    input  logic                  vector,
    input  logic [FunctWidth-1:0] funct,
    input  logic [3:0]            aluFlags,
    output logic                  pcSrc,
    output logic                  memToReg,
    output logic                  memWrite,
    output logic                  aluSrc,
    output logic                  regWrite,
    output aluOp_e                aluControl,
    output immSrc_e               immSrc
);

    logic       regWriteDec;
    logic       memWriteDec;
    logic       flagWrite;
    logic       branch;
    logic       branchEq;
    logic [3:0] storedFlags;   // NZCV kept between instructions

    always_comb begin
        regWriteDec = 1'b0;
        memWriteDec = 1'b0;
        flagWrite   = 1'b0;
        branch      = 1'b0;
        branchEq    = 1'b0;
        aluSrc      = 1'b0;
        memToReg    = 1'b0;
        aluControl  = AluAdd;   // address and target math is an add
        immSrc      = ImmNone;

        // vector instructions are not implemented and fall through as no-ops
        if (!vector) begin
            case (opcode)
                OpAluReg: begin
                    regWriteDec = 1'b1;
                    flagWrite   = 1'b1;
                    aluControl  = aluOp_e'(funct);   // funct 111 yields zero
                end
                OpAddImm: begin
                    regWriteDec = 1'b1;
                    flagWrite   = 1'b1;
                    aluSrc      = 1'b1;
                    immSrc      = ImmSigned12;
                end
                OpLoad: begin
                    regWriteDec = 1'b1;
                    aluSrc      = 1'b1;
                    immSrc      = ImmSigned12;
                    memToReg    = 1'b1;        // result from data memory
                end
                OpStore: begin
                    memWriteDec = 1'b1;
                    aluSrc      = 1'b1;
                    immSrc      = ImmSigned12;
                end
                OpBranch: begin
                    branch = 1'b1;
                    aluSrc = 1'b1;
                    immSrc = ImmSigned12;      // target is Rs plus offset
                end
                OpBranchEq: begin
                    branchEq = 1'b1;
                    aluSrc   = 1'b1;
                    immSrc   = ImmSigned12;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            storedFlags <= '0;
        end else if (flagWrite) begin
            storedFlags <= aluFlags;
        end
    end

    // equal test uses Z from an earlier instruction
    assign pcSrc = branch | (branchEq & storedFlags[FlagZ]);

    // no state changes outside the core while reset is high
    assign regWrite = regWriteDec & ~reset;
    assign memWrite = memWriteDec & ~reset;

endmodule

`default_nettype wire

/* design/cpuPkg.sv */
// cpuPkg
// instruction field positions, flag positions and decode enums for the scalar core
`default_nettype none

package cpuPkg;

    localparam int InstrWidth   = 24;
    localparam int RegAddrWidth = 4;
    localparam int ImmWidth     = 12;
    localparam int FunctWidth   = 3;

    // field positions inside the instruction word
    localparam int OpcodeLsb = 21;
    localparam int VectorBit = 20;
    localparam int RdLsb     = 16;
    localparam int RsLsb     = 12;
    localparam int RtLsb     = 8;

    // bit positions in the NZCV flag vector
    localparam int FlagN = 3;
    localparam int FlagZ = 2;
    localparam int FlagC = 1;
    localparam int FlagV = 0;

    typedef enum logic [2:0] {
        OpAluReg   = 3'b000,   // register ALU operation
        OpAddImm   = 3'b001,
        OpLoad     = 3'b010,
        OpStore    = 3'b011,
        OpBranch   = 3'b100,
        OpBranchEq = 3'b101    // 110 and 111 reserved as no-ops
    } opcode_e;

    // matches the function field of register ALU operations
    typedef enum logic [2:0] {
        AluAdd   = 3'b000,
        AluSub   = 3'b001,
        AluAnd   = 3'b010,
        AluOr    = 3'b011,
        AluXor   = 3'b100,
        AluSlt   = 3'b101,     // signed set-less-than
        AluPassB = 3'b110
    } aluOp_e;

    typedef enum logic [1:0] {
        ImmNone     = 2'b00,
        ImmSigned12 = 2'b01
    } immSrc_e;

endpackage

`default_nettype wire

/* design/immExtend.sv */
// immExtend
// widens the 12-bit immediate field to the datapath width
`timescale 1ns/1ps
`default_nettype none

module immExtend
    import cpuPkg::*;
#(
    parameter int N = 24
) (
    input  logic [ImmWidth-1:0] immField,
    input  immSrc_e             immSrc,
    output logic [N-1:0]        extImm
);

    always_comb begin
        case (immSrc)
            ImmSigned12: extImm = {{(N-ImmWidth){immField[ImmWidth-1]}}, immField};
            default:     extImm = '0;   // ImmNone
        endcase
    end

endmodule

`default_nettype wire

/* design/processor.sv */
// processor
// single-cycle scalar core top that splits the instruction fields and wires the datapath
`timescale 1ns/1ps
`default_nettype none

module processor
    import cpuPkg::*;
#(
    parameter int N = 24
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [InstrWidth-1:0] instruction,      // from instruction memory
    input  logic [N-1:0]          readScalarData,   // load data in the same cycle
    output logic [N-1:0]          pcAddress,
    output logic [N-1:0]          aluScalarResult,  // data memory address
    output logic [N-1:0]          writeScalarData,
    output logic                  memWrite
);

    opcode_e                 opcode;
    logic                    vector;
    logic [RegAddrWidth-1:0] rd;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [FunctWidth-1:0]   funct;
    logic [ImmWidth-1:0]     immField;

    logic         pcSrc;
    logic         memToReg;
    logic         aluSrc;
    logic         regWrite;
    aluOp_e       aluControl;
    immSrc_e      immSrc;

    logic [N-1:0] pcPlusTwo;
    logic [N-1:0] srcA;
    logic [N-1:0] srcB;
    logic [N-1:0] rtData;
    logic [N-1:0] extImm;
    logic [N-1:0] aluResult;
    logic [3:0]   aluFlags;
    logic [N-1:0] result;

    // instruction fields
    assign opcode   = opcode_e'(instruction[OpcodeLsb +: 3]);
    assign vector   = instruction[VectorBit];
    assign rd       = instruction[RdLsb +: RegAddrWidth];
    assign rs       = instruction[RsLsb +: RegAddrWidth];
    assign rt       = instruction[RtLsb +: RegAddrWidth];
    assign funct    = instruction[FunctWidth-1:0];
    assign immField = instruction[ImmWidth-1:0];

    programCounter #(.N(N)) u_programCounter (
        .clk          (clk),
        .reset        (reset),
        .pcSrc        (pcSrc),
        .branchTarget (result),
        .pcAddress    (pcAddress),
        .pcPlusTwo    (pcPlusTwo)
    );

    controlUnit u_controlUnit (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .vector     (vector),
        .funct      (funct),
        .aluFlags   (aluFlags),
        .pcSrc      (pcSrc),
        .memToReg   (memToReg),
        .memWrite   (memWrite),
        .aluSrc     (aluSrc),
        .regWrite   (regWrite),
        .aluControl (aluControl),
        .immSrc     (immSrc)
    );

    registerFile #(.N(N)) u_registerFile (
        .clk         (clk),
        .reset       (reset),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .writeAddr   (rd),
        .writeEnable (regWrite),
        .writeData   (result),
        .pcPlusTwo   (pcPlusTwo),
        .readDataA   (srcA),
        .readDataB   (rtData)
    );

    immExtend #(.N(N)) u_immExtend (
        .immField (immField),
        .immSrc   (immSrc),
        .extImm   (extImm)
    );

    assign srcB = aluSrc ? extImm : rtData;   // immediate forms use extImm

    scalarAlu #(.N(N)) u_scalarAlu (
        .srcA       (srcA),
        .srcB       (srcB),
        .aluControl (aluControl),
        .result     (aluResult),
        .flags      (aluFlags)
    );

    assign result          = memToReg ? readScalarData : aluResult;
    assign aluScalarResult = aluResult;
    assign writeScalarData = rtData;   // store data is register Rt

endmodule

`default_nettype wire

/* design/programCounter.sv */
// programCounter
// word-address program counter that loads the increment or branch target each edge
`timescale 1ns/1ps
`default_nettype none

module programCounter #(
    parameter int N = 24
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         pcSrc,
    input  logic [N-1:0] branchTarget,
    output logic [N-1:0] pcAddress,
    output logic [N-1:0] pcPlusTwo
);

    logic [N-1:0] pcPlusOne;
    logic [N-1:0] nextPc;

    assign pcPlusOne = pcAddress + N'(1);   // one word per instruction
    assign pcPlusTwo = pcAddress + N'(2);   // value seen through register 15

    assign nextPc = pcSrc ? branchTarget : pcPlusOne;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcAddress <= '0;
        end else begin
            pcAddress <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* design/registerFile.sv */
// registerFile
// fifteen general registers plus register 15 which reads as PC plus 2
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import cpuPkg::*;
#(
    parameter int N = 24
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [RegAddrWidth-1:0] readAddrA,
    input  logic [RegAddrWidth-1:0] readAddrB,
    input  logic [RegAddrWidth-1:0] writeAddr,
    input  logic                    writeEnable,
    input  logic [N-1:0]            writeData,
    input  logic [N-1:0]            pcPlusTwo,
    output logic [N-1:0]            readDataA,
    output logic [N-1:0]            readDataB
);

    localparam int PcReg = (1 << RegAddrWidth) - 1;   // register 15

    logic [N-1:0] regs [PcReg];   // no storage behind register 15

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PcReg; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != RegAddrWidth'(PcReg))) begin
            regs[writeAddr] <= writeData;   // writes to 15 are dropped
        end
    end

    always_comb begin
        if (readAddrA == RegAddrWidth'(PcReg)) begin
            readDataA = pcPlusTwo;
        end else begin
            readDataA = regs[readAddrA];
        end

        if (readAddrB == RegAddrWidth'(PcReg)) begin
            readDataB = pcPlusTwo;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

`default_nettype wire

/* design/scalarAlu.sv */
// scalarAlu
// N-bit integer ALU with NZCV flag outputs
`timescale 1ns/1ps
`default_nettype none

module scalarAlu
    import cpuPkg::*;
#(
    parameter int N = 24
) (
    input  logic [N-1:0] srcA,
    input  logic [N-1:0] srcB,
    input  aluOp_e       aluControl,
    output logic [N-1:0] result,
    output logic [3:0]   flags
);

    logic [N:0] sum;    // carry in the top bit
    logic [N:0] diff;   // top bit set means no borrow
    logic       carry;
    logic       overflow;

    assign sum  = {1'b0, srcA} + {1'b0, srcB};
    assign diff = {1'b0, srcA} + {1'b0, ~srcB} + (N+1)'(1);

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (aluControl)
            AluAdd: begin
                result   = sum[N-1:0];
                carry    = sum[N];
                overflow = (srcA[N-1] == srcB[N-1]) && (sum[N-1] != srcA[N-1]);
            end
            AluSub: begin
                result   = diff[N-1:0];
                carry    = diff[N];
                overflow = (srcA[N-1] != srcB[N-1]) && (diff[N-1] != srcA[N-1]);
            end
            AluAnd:   result = srcA & srcB;
            AluOr:    result = srcA | srcB;
            AluXor:   result = srcA ^ srcB;
            AluSlt:   result = N'($signed(srcA) < $signed(srcB));
            AluPassB: result = srcB;
            default:  result = '0;   // unused function code
        endcase
    end

    always_comb begin
        flags        = '0;
        flags[FlagN] = result[N-1];
        flags[FlagZ] = (result == '0);
        flags[FlagC] = carry;
        flags[FlagV] = overflow;
    end

endmodule

`default_nettype wire

/* scalarCpu.f */
design/cpuPkg.sv
design/programCounter.sv
design/controlUnit.sv
design/registerFile.sv
design/immExtend.sv
design/scalarAlu.sv
design/processor.sv
tests/dataMemoryModel.sv
tests/processorTb.sv

/* tests/dataMemoryModel.sv */
// dataMemoryModel
// testbench data memory with combinational read and a write on the rising edge
`timescale 1ns/1ps
`default_nettype none

module dataMemoryModel #(
    parameter int N        = 24,
    parameter int AddrBits = 12
) (
    input  logic         clk,
    input  logic         memWrite,
    input  logic [N-1:0] address,
    input  logic [N-1:0] writeData,
    output logic [N-1:0] readData
);

    localparam int Depth = 1 << AddrBits;

    logic [N-1:0]        mem [Depth];
    logic [AddrBits-1:0] index;   // upper address bits alias

    assign index    = address[AddrBits-1:0];
    assign readData = mem[index];   // load data in the same cycle

    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = ~N'(i);   // distinct word per address
        end
    end

    always @(posedge clk) begin
        if (memWrite) begin
            mem[index] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* tests/processorGolden.txt */
# I word: program word at the next ROM address | S addr data: expected store in order
# H addr: halt address, all values in hex
I 210123
I 220045
I 280FFB
I 031200
I 041201
I 051202
I 061203
I 071204
I 098105
I 0B0206
I 600301
S 000301 000168
I 600402
S 000402 0000DE
I 600503
S 000503 000001
I 600604
S 000604 000167
I 600705
S 000705 000166
I 600806
S FFF806 FFFFFB
I 600907
S FFF907 000001
I 600B08
S FFFB08 000045
I 4D0301
I 600D09
S FFFD09 000168
I 2F0777
I 600F0A
S FFFF0A 000017
I 310555
I C10555
I 700100
I 60010B
S 00010B 000123
I 80F001
I 60010C
I 60020D
I 0E1101
I A0F000
I 60010E
I 60020F
S 00020F 000045
I 0E1201
I A0F000
I 600310
S 000310 000168
I 80FFFE
H 000024

/* tests/processorTb.sv */
// processorTb
// runs the golden program on the scalar core and checks every data memory store
`timescale 1ns/1ps
`default_nettype none

module processorTb
    import cpuPkg::*;
();

    localparam int N           = 24;
    localparam int RomDepth    = 64;
    localparam int RomBits     = $clog2(RomDepth);
    localparam int HaltTimeout = 2000;   // cycles after reset
    localparam logic [InstrWidth-1:0] ReservedNop = 24'hC00000;

    logic                  clk;
    logic                  reset;
    logic [InstrWidth-1:0] instruction;
    logic [N-1:0]          readScalarData;
    logic [N-1:0]          pcAddress;
    logic [N-1:0]          aluScalarResult;
    logic [N-1:0]          writeScalarData;
    logic                  memWrite;

    logic [InstrWidth-1:0] rom [RomDepth];
    logic [N-1:0]          expAddr [$];
    logic [N-1:0]          expData [$];
    logic [N-1:0]          haltAddr;
    logic [InstrWidth-1:0] word;
    logic [N-1:0]          fieldA;
    logic [N-1:0]          fieldB;
    logic [8*160-1:0]      lineBuf;
    string                 tag;
    int                    fd;
    int                    n;
    int                    romCount = 0;
    int                    storeIdx = 0;
    int                    firstBranch = -1;   // last index of straight-line code
    int                    cycles;
    int                    haltCount;

    always #20 clk = ~clk;

    // instruction memory answers in the same cycle
    assign instruction = (pcAddress < N'(RomDepth)) ? rom[pcAddress[RomBits-1:0]] : ReservedNop;

    processor #(.N(N)) i_dut (
        .clk             (clk),
        .reset           (reset),
        .instruction     (instruction),
        .readScalarData  (readScalarData),
        .pcAddress       (pcAddress),
        .aluScalarResult (aluScalarResult),
        .writeScalarData (writeScalarData),
        .memWrite        (memWrite)
    );

    dataMemoryModel #(.N(N), .AddrBits(12)) u_dataMemory (
        .clk       (clk),
        .memWrite  (memWrite),
        .address   (aluScalarResult),
        .writeData (writeScalarData),
        .readData  (readScalarData)
    );

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareWord(input string name, input logic [N-1:0] got,
                               input logic [N-1:0] expected);
        if (got !== expected) begin
            stopRun($sformatf("[ERROR] %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic compareOpcodeRange(input string name, input opcode_e got,
                                      input opcode_e expected);
        if (got !== expected) begin
            stopRun($sformatf("[ERROR] %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic loadGolden();
        fd = $fopen("tests/processorGolden.txt", "r");
        if (fd == 0) begin
            stopRun("could not open tests/processorGolden.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n == 1) begin
                if (tag.getc(0) == "#") begin
                    n = $fgets(lineBuf, fd);   // skip comment text
                end else if (tag == "I") begin
                    n = $fscanf(fd, "%h", word);
                    if (romCount >= RomDepth) begin
                        stopRun("program does not fit in the instruction ROM");
                    end
                    if (firstBranch < 0 && !word[VectorBit] &&
                        (word[OpcodeLsb +: 3] == OpBranch ||
                         word[OpcodeLsb +: 3] == OpBranchEq)) begin
                        firstBranch = romCount;
                    end
                    rom[romCount] = word;
                    romCount++;
                end else if (tag == "S") begin
                    n = $fscanf(fd, "%h %h", fieldA, fieldB);
                    expAddr.push_back(fieldA);
                    expData.push_back(fieldB);
                end else if (tag == "H") begin
                    n = $fscanf(fd, "%h", haltAddr);
                end else begin
                    stopRun($sformatf("unknown tag %s in the golden file", tag));
                end
            end
        end
        $fclose(fd);
    endtask

    // a store happens on the edge where memWrite is high
    always @(posedge clk) begin
        if (!reset && memWrite) begin
            if (storeIdx >= expAddr.size()) begin
                stopRun("a store happened after the last expected store");
            end else begin
                compareWord("aluScalarResult", aluScalarResult, expAddr[storeIdx]);
                compareWord("writeScalarData", writeScalarData, expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        void'($urandom(90));
        for (int i = 0; i < RomDepth; i++) begin
            rom[i] = {2'b11, 22'($urandom)};   // reserved opcodes only
        end
        loadGolden();

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        compareWord("pcAddress", pcAddress, '0);
        compareWord("memWrite", N'(memWrite), '0);

        cycles    = 1;
        haltCount = 0;
        while (haltCount < 2) begin
            if (cycles > HaltTimeout) begin
                stopRun("timeout, pcAddress never settled at the halt address");
            end else begin
                @(posedge clk);
                if (cycles <= firstBranch) begin
                    compareWord("pcAddress", pcAddress, N'(cycles));   // one word per cycle
                end
                if (pcAddress == haltAddr) begin
                    haltCount++;
                end else begin
                    haltCount = 0;
                end
                cycles++;
            end
        end

        compareOpcodeRange("opcode", opcode_e'(instruction[OpcodeLsb +: 3]), OpBranch);
        if (storeIdx != expAddr.size()) begin
            stopRun($sformatf("only %0d of %0d expected stores were seen",
                              storeIdx, expAddr.size()));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
